/* logic/lsu_pkg.sv */
package lsu_pkg;

  // access width as coded in funct3[1:0].
  typedef enum logic [1:0] {
    INT_SIZE_BYTE = 2'b00,
    INT_SIZE_HALF = 2'b01,
    INT_SIZE_WORD = 2'b10
  } int_size_t;

  // one instruction word seen as a load or as a store.
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } stype;
  } instr_t;

  localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE = 7'b0100011;

  localparam int RAM_WORDS_LOG2 = 10;
  localparam logic [7:0] WAIT_LFSR_SEED = 8'hb4;

  // bus master states.
  localparam logic [1:0] ST_READY      = 2'd0;
  localparam logic [1:0] ST_SEND_READ  = 2'd1;
  localparam logic [1:0] ST_SEND_WRITE = 2'd2;
  localparam logic [1:0] ST_WAIT_RESP  = 2'd3;

  function automatic logic [3:0] size_to_bytemask(input int_size_t size,
                                                  input logic [1:0] offset);
    logic [3:0] mask;
    case (size)
      INT_SIZE_BYTE: mask = 4'b0001;
      INT_SIZE_HALF: mask = 4'b0011;
      default:       mask = 4'b1111;
    endcase
    return mask << offset;
  endfunction

  function automatic logic [31:0] extend_load(input logic [31:0] word, input int_size_t size,
                                              input logic [1:0] offset, input bit zero_extend);
    logic [31:0] lane;
    lane = word >> {offset, 3'b000};
    case (size)
      INT_SIZE_BYTE: return zero_extend ? {24'h0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      INT_SIZE_HALF: return zero_extend ? {16'h0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
      default:       return lane;
    endcase
  endfunction

endpackage

/* logic/lsu_decode.sv */
`timescale 1ns/100ps

module lsu_decode (
  input  bit                clk,
  input  bit                rst,
  input  bit                issue,
  input  lsu_pkg::instr_t   instr,
  input  logic [31:0]       rs1_value,
  input  logic [31:0]       rs2_value,
  input  bit                ready,
  output bit                read,
  output bit                write,
  output logic [31:0]       address,
  output lsu_pkg::int_size_t size,
  output bit                zero_extend,
  output logic [31:0]       to_bus,
  output logic [4:0]        load_rd,
  output bit                load_done,
  output bit                fault
);
  import lsu_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        is_load;
  logic        is_store;
  logic [31:0] imm_ext;
  logic [31:0] addr_next;
  int_size_t   size_next;
  logic [3:0]  lane_mask;
  logic        bad_funct3;
  logic        misaligned;
  logic        illegal;
  logic        load_pending;
  logic        ready_q;
  logic [4:0]  pending_rd;
  logic [4:0]  done_rd;

  // opcode and funct3 sit at the same bits in both formats.
  assign opcode   = instr.itype.opcode;
  assign funct3   = instr.itype.funct3;
  assign is_load  = opcode == OPCODE_LOAD;
  assign is_store = opcode == OPCODE_STORE;

  always_comb begin
    if (is_store) begin
      imm_ext = {{20{instr.stype.imm_hi[6]}}, instr.stype.imm_hi, instr.stype.imm_lo};
    end else begin
      imm_ext = {{20{instr.itype.imm[11]}}, instr.itype.imm};
    end
  end

  assign addr_next = rs1_value + imm_ext;

  always_comb begin
    case (funct3[1:0])
      2'b00:   size_next = INT_SIZE_BYTE;
      2'b01:   size_next = INT_SIZE_HALF;
      default: size_next = INT_SIZE_WORD;
    endcase
  end

  // size 3 and a zero-extended word are reserved.
  assign bad_funct3 = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);

  // natural alignment keeps the offset clear of mask bits above lane 0.
  assign lane_mask  = size_to_bytemask(size_next, 2'b00);
  assign misaligned = |(addr_next[1:0] & lane_mask[2:1]);
  assign illegal    = !(is_load || is_store) || bad_funct3 || misaligned;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      read         <= 1'b0;
      write        <= 1'b0;
      fault        <= 1'b0;
      load_pending <= 1'b0;
      ready_q      <= 1'b1;
    end else begin
      read    <= issue && is_load && !illegal;
      write   <= issue && is_store && !illegal;
      fault   <= issue && illegal;
      ready_q <= ready;
      if (issue && is_load && !illegal) begin
        load_pending <= 1'b1;
      end else if (load_done) begin
        load_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      address     <= addr_next;
      size        <= size_next;
      zero_extend <= funct3[2];
      to_bus      <= rs2_value;
    end
    if (issue && is_load) begin
      pending_rd <= instr.itype.rd;
    end
    if (load_done) begin
      done_rd <= pending_rd;
    end
  end

  // a load ends when the bus master goes back to ready.
  assign load_done = load_pending && ready && !ready_q;
  assign load_rd   = load_done ? pending_rd : done_rd;

  issue_only_when_ready: assert property (
    @(posedge clk) disable iff (!rst) issue |-> ready
  );

endmodule

/* logic/data_manager.sv */
`timescale 1ns/100ps

module data_manager (
  input  bit                 clk,
  input  bit                 rst,
  input  bit                 read,
  input  bit                 write,
  input  logic [31:0]        address,
  input  lsu_pkg::int_size_t size,
  input  bit                 zero_extend,
  input  logic [31:0]        to_bus,
  output logic [31:0]        from_bus,
  output bit                 ready,
  output logic [31:0]        avm_address,
  output logic [3:0]         avm_byteenable,
  output bit                 avm_read,
  output bit                 avm_write,
  output logic [31:0]        avm_writedata,
  input  logic [31:0]        avm_readdata,
  input  bit                 avm_readdatavalid,
  input  bit                 avm_waitrequest
);
  import lsu_pkg::*;

  logic [1:0] state;
  logic       start;
  int_size_t  size_q;
  logic [1:0] offset_q;
  logic       zero_extend_q;

  assign avm_read  = state == ST_SEND_READ;
  assign avm_write = state == ST_SEND_WRITE;
  assign ready     = state == ST_READY;

  assign start = (state == ST_READY) && (read || write);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= ST_READY;
    end else begin
      case (state)
        ST_READY: begin
          if (read) begin
            state <= ST_SEND_READ;
          end else if (write) begin
            state <= ST_SEND_WRITE;
          end
        end

        // held on the bus until the agent stops stalling.
        ST_SEND_READ: begin
          if (!avm_waitrequest) begin
            state <= ST_WAIT_RESP;
          end
        end

        ST_SEND_WRITE: begin
          if (!avm_waitrequest) begin
            state <= ST_READY;
          end
        end

        ST_WAIT_RESP: begin
          if (avm_readdatavalid) begin
            state <= ST_READY;
          end
        end

        default: state <= ST_READY;
      endcase
    end
  end

  // request fields and access shape are captured once per access.
  always_ff @(posedge clk) begin
    if (start) begin
      avm_address    <= {address[31:2], 2'b00};
      avm_byteenable <= size_to_bytemask(size, address[1:0]);
      avm_writedata  <= to_bus << {address[1:0], 3'b000};
      size_q         <= size;
      offset_q       <= address[1:0];
      zero_extend_q  <= zero_extend;
    end
    if (state == ST_WAIT_RESP && avm_readdatavalid) begin
      from_bus <= extend_load(avm_readdata, size_q, offset_q, zero_extend_q);
    end
  end

  no_read_and_write: assert property (
    @(posedge clk) disable iff (!rst) !(read && write)
  );

  request_stable_while_stalled: assert property (
    @(posedge clk) disable iff (!rst)
      (avm_read || avm_write) && avm_waitrequest
      |=> $stable({avm_read, avm_write, avm_address, avm_byteenable})
          && (!avm_write || $stable(avm_writedata))
  );

endmodule

/* logic/avalon_data_ram.sv */
`timescale 1ns/100ps

module avalon_data_ram (
  input  bit          clk,
  input  bit          rst,
  input  logic [31:0] avm_address,
  input  logic [3:0]  avm_byteenable,
  input  bit          avm_read,
  input  bit          avm_write,
  input  logic [31:0] avm_writedata,
  output logic [31:0] avm_readdata,
  output bit          avm_readdatavalid,
  output bit          avm_waitrequest
);
  import lsu_pkg::*;

  localparam int DEPTH = 2 ** RAM_WORDS_LOG2;

  logic [31:0]               mem [DEPTH];
  logic [RAM_WORDS_LOG2-1:0] index;
  logic [7:0]                lfsr;
  logic                      accept_read;
  logic                      accept_write;

  // word address wrapped to the depth.
  assign index = avm_address[RAM_WORDS_LOG2+1:2];

  // about half of all cycles stall.
  assign avm_waitrequest = lfsr[0];

  assign accept_read  = avm_read && !avm_waitrequest;
  assign accept_write = avm_write && !avm_waitrequest;

  // free running LFSR on x^8 + x^6 + x^5 + x^4 + 1.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      lfsr <= WAIT_LFSR_SEED;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      avm_readdatavalid <= 1'b0;
    end else begin
      avm_readdatavalid <= accept_read;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_write) begin
      for (int b = 0; b < 4; b++) begin
        if (avm_byteenable[b]) begin
          mem[index][8*b +: 8] <= avm_writedata[8*b +: 8];
        end
      end
    end
    if (accept_read) begin
      avm_readdata <= mem[index];
    end
  end

  // the host holds one read at a time and is idle while its data returns.
  rdv_without_new_request: assert property (
    @(posedge clk) disable iff (!rst)
      avm_readdatavalid |-> !avm_read && !avm_write
  );

endmodule

/* logic/load_store_unit.sv */
`timescale 1ns/100ps

module load_store_unit (
  input  bit              clk,
  input  bit              rst,
  input  bit              issue,
  input  lsu_pkg::instr_t instr,
  input  logic [31:0]     rs1_value,
  input  logic [31:0]     rs2_value,
  output bit              ready,
  output logic [31:0]     load_data,
  output logic [4:0]      load_rd,
  output bit              load_done,
  output bit              fault
);
  import lsu_pkg::*;

  // decoder to bus master.
  bit          read;
  bit          write;
  logic [31:0] address;
  int_size_t   size;
  bit          zero_extend;
  logic [31:0] to_bus;

  // bus master to RAM.
  logic [31:0] avm_address;
  logic [3:0]  avm_byteenable;
  bit          avm_read;
  bit          avm_write;
  logic [31:0] avm_writedata;
  logic [31:0] avm_readdata;
  bit          avm_readdatavalid;
  bit          avm_waitrequest;

  lsu_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .issue       (issue),
    .instr       (instr),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .ready       (ready),
    .read        (read),
    .write       (write),
    .address     (address),
    .size        (size),
    .zero_extend (zero_extend),
    .to_bus      (to_bus),
    .load_rd     (load_rd),
    .load_done   (load_done),
    .fault       (fault)
  );

  data_manager u_data_manager (
    .clk               (clk),
    .rst               (rst),
    .read              (read),
    .write             (write),
    .address           (address),
    .size              (size),
    .zero_extend       (zero_extend),
    .to_bus            (to_bus),
    .from_bus          (load_data),
    .ready             (ready),
    .avm_address       (avm_address),
    .avm_byteenable    (avm_byteenable),
    .avm_read          (avm_read),
    .avm_write         (avm_write),
    .avm_writedata     (avm_writedata),
    .avm_readdata      (avm_readdata),
    .avm_readdatavalid (avm_readdatavalid),
    .avm_waitrequest   (avm_waitrequest)
  );

  avalon_data_ram u_ram (
    .clk               (clk),
    .rst               (rst),
    .avm_address       (avm_address),
    .avm_byteenable    (avm_byteenable),
    .avm_read          (avm_read),
    .avm_write         (avm_write),
    .avm_writedata     (avm_writedata),
    .avm_readdata      (avm_readdata),
    .avm_readdatavalid (avm_readdatavalid),
    .avm_waitrequest   (avm_waitrequest)
  );

endmodule

/* testbench/load_store_unit_tb.sv */
`timescale 1ns/100ps

module load_store_unit_tb;
  import lsu_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_RANDOM = 300;
  localparam int WINDOW_WORDS = 32;
  localparam logic [31:0] WINDOW_BASE = 32'h0000_0400;
  localparam int BYTE_BITS = RAM_WORDS_LOG2 + 2;

  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  bit          clk;
  bit          rst;
  bit          issue;
  logic [31:0] instr;
  logic [31:0] rs1_value;
  logic [31:0] rs2_value;
  bit          ready;
  logic [31:0] load_data;
  logic [4:0]  load_rd;
  bit          load_done;
  bit          fault;

  logic [31:0] tab_instr[$];
  logic [31:0] tab_rs1[$];
  logic [31:0] tab_rs2[$];
  bit          tab_fault[$];
  logic [31:0] tab_value[$];
  bit          table_ready;

  logic [7:0]  shadow [2 ** BYTE_BITS];
  integer      seed = 32'h6f7a_51fd;

  load_store_unit UUT (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .instr     (instr),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .ready     (ready),
    .load_data (load_data),
    .load_rd   (load_rd),
    .load_done (load_done),
    .fault     (fault)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  // RV32 I-type and S-type layouts with rs1 as x2 and rs2 as x3.
  function automatic logic [31:0] encode_load(input logic [2:0] funct3, input logic [4:0] rd,
                                              input logic [11:0] imm);
    return {imm, 5'd2, funct3, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] encode_store(input logic [2:0] funct3, input logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd2, funct3, imm[4:0], 7'b0100011};
  endfunction

  task automatic add_entry(input logic [31:0] word, input logic [31:0] rs1,
                           input logic [31:0] rs2, input bit exp_fault,
                           input logic [31:0] exp_value);
    tab_instr.push_back(word);
    tab_rs1.push_back(rs1);
    tab_rs2.push_back(rs2);
    tab_fault.push_back(exp_fault);
    tab_value.push_back(exp_value);
  endtask

  task automatic add_store(input logic [31:0] word, input logic [31:0] rs1,
                           input logic [31:0] rs2);
    add_entry(word, rs1, rs2, 1'b0, 32'h0);
  endtask

  task automatic add_load(input logic [31:0] word, input logic [31:0] rs1,
                          input logic [31:0] exp_value);
    add_entry(word, rs1, 32'h0, 1'b0, exp_value);
  endtask

  task automatic add_fault(input logic [31:0] word, input logic [31:0] rs2);
    add_entry(word, 32'h0000_0080, rs2, 1'b1, 32'h0);
  endtask

  task automatic build_table();
    add_store(encode_store(F3_W, 12'h010), 32'h0000_0030, 32'h1234_5678);
    add_load(encode_load(F3_W, 5'd5, 12'hff0), 32'h0000_0050, 32'h1234_5678);
    // byte lanes of the word at 0x80.
    add_store(encode_store(F3_W, 12'h000), 32'h0000_0080, 32'ha5a5_a5a5);
    add_store(encode_store(F3_B, 12'h001), 32'h0000_0080, 32'hffff_ff3c);
    add_load(encode_load(F3_W, 5'd6, 12'h000), 32'h0000_0080, 32'ha5a5_3ca5);
    add_store(encode_store(F3_B, 12'h003), 32'h0000_0080, 32'h0000_00c7);
    add_store(encode_store(F3_B, 12'h000), 32'h0000_0080, 32'h0000_015e);
    add_store(encode_store(F3_B, 12'hffe), 32'h0000_0084, 32'h0000_0001);
    add_load(encode_load(F3_W, 5'd7, 12'h000), 32'h0000_0080, 32'hc701_3c5e);
    // half lanes of the word at 0x84.
    add_store(encode_store(F3_W, 12'h004), 32'h0000_0080, 32'h0000_0000);
    add_store(encode_store(F3_H, 12'h006), 32'h0000_0080, 32'h1234_8001);
    add_load(encode_load(F3_W, 5'd8, 12'h004), 32'h0000_0080, 32'h8001_0000);
    add_store(encode_store(F3_H, 12'h004), 32'h0000_0080, 32'habcd_7ffe);
    add_load(encode_load(F3_W, 5'd9, 12'h004), 32'h0000_0080, 32'h8001_7ffe);
    add_store(encode_store(F3_W, 12'h008), 32'h0000_0080, 32'h80ff_7f81);
    // sign and zero extension at every legal offset.
    add_load(encode_load(F3_B, 5'd10, 12'h000), 32'h0000_0080, 32'h0000_005e);
    add_load(encode_load(F3_B, 5'd11, 12'h001), 32'h0000_0080, 32'h0000_003c);
    add_load(encode_load(F3_B, 5'd12, 12'h002), 32'h0000_0080, 32'h0000_0001);
    add_load(encode_load(F3_B, 5'd13, 12'h003), 32'h0000_0080, 32'hffff_ffc7);
    add_load(encode_load(F3_BU, 5'd14, 12'h000), 32'h0000_0080, 32'h0000_005e);
    add_load(encode_load(F3_BU, 5'd15, 12'h001), 32'h0000_0080, 32'h0000_003c);
    add_load(encode_load(F3_BU, 5'd16, 12'h002), 32'h0000_0080, 32'h0000_0001);
    add_load(encode_load(F3_BU, 5'd17, 12'h003), 32'h0000_0080, 32'h0000_00c7);
    add_load(encode_load(F3_B, 5'd18, 12'h008), 32'h0000_0080, 32'hffff_ff81);
    add_load(encode_load(F3_B, 5'd19, 12'h009), 32'h0000_0080, 32'h0000_007f);
    add_load(encode_load(F3_B, 5'd20, 12'h00a), 32'h0000_0080, 32'hffff_ffff);
    add_load(encode_load(F3_B, 5'd21, 12'h00b), 32'h0000_0080, 32'hffff_ff80);
    add_load(encode_load(F3_BU, 5'd22, 12'h00a), 32'h0000_0080, 32'h0000_00ff);
    add_load(encode_load(F3_BU, 5'd23, 12'h00b), 32'h0000_0080, 32'h0000_0080);
    add_load(encode_load(F3_H, 5'd24, 12'h004), 32'h0000_0080, 32'h0000_7ffe);
    add_load(encode_load(F3_H, 5'd25, 12'h006), 32'h0000_0080, 32'hffff_8001);
    add_load(encode_load(F3_H, 5'd26, 12'h008), 32'h0000_0080, 32'h0000_7f81);
    add_load(encode_load(F3_H, 5'd27, 12'h00a), 32'h0000_0080, 32'hffff_80ff);
    add_load(encode_load(F3_HU, 5'd28, 12'h006), 32'h0000_0080, 32'h0000_8001);
    add_load(encode_load(F3_HU, 5'd29, 12'h00a), 32'h0000_0080, 32'h0000_80ff);
    add_load(encode_load(F3_HU, 5'd30, 12'h008), 32'h0000_0080, 32'h0000_7f81);
    // misaligned, unknown opcode and reserved funct3.
    add_fault(encode_load(F3_H, 5'd1, 12'h005), 32'h0);
    add_fault(encode_load(F3_W, 5'd1, 12'h002), 32'h0);
    add_fault(encode_store(F3_W, 12'h001), 32'hdead_beef);
    add_fault(encode_store(F3_H, 12'h007), 32'hffff_ffff);
    add_fault(encode_store(F3_W, 12'h006), 32'hdead_beef);
    add_fault(32'h00b5_0533, 32'hdead_beef);
    add_fault(encode_load(3'b011, 5'd1, 12'h000), 32'h0);
    add_fault(encode_load(3'b110, 5'd1, 12'h000), 32'h0);
    add_fault(encode_load(3'b111, 5'd1, 12'h000), 32'h0);
    add_fault(encode_store(3'b011, 12'h000), 32'hdead_beef);
    add_fault(encode_store(3'b111, 12'h004), 32'hdead_beef);
    // memory untouched by the faulting stores.
    add_load(encode_load(F3_W, 5'd31, 12'h000), 32'h0000_0080, 32'hc701_3c5e);
    add_load(encode_load(F3_W, 5'd1, 12'h004), 32'h0000_0080, 32'h8001_7ffe);
  endtask

  task automatic shadow_store(input logic [31:0] addr, input logic [1:0] size_code,
                              input logic [31:0] data);
    logic [BYTE_BITS-1:0] idx;
    for (int b = 0; b < (1 << size_code); b++) begin
      idx = addr[BYTE_BITS-1:0] + BYTE_BITS'(b);
      shadow[idx] = data[8*b +: 8];
    end
  endtask

  // gathers the addressed bytes with the lowest address in the lowest lane.
  function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                input logic [1:0] size_code, input bit zext);
    logic [BYTE_BITS-1:0] idx;
    logic [31:0]          raw;
    raw = 32'h0;
    for (int b = 0; b < (1 << size_code); b++) begin
      idx = addr[BYTE_BITS-1:0] + BYTE_BITS'(b);
      raw[8*b +: 8] = shadow[idx];
    end
    case (size_code)
      2'b00:   return zext ? raw : {{24{raw[7]}}, raw[7:0]};
      2'b01:   return zext ? raw : {{16{raw[15]}}, raw[15:0]};
      default: return raw;
    endcase
  endfunction

  // one instruction from issue to fault or to ready rising again.
  task automatic run_access(input logic [31:0] word, input logic [31:0] rs1,
                            input logic [31:0] rs2, output bit faulted, output bit loaded,
                            output logic [31:0] data, output logic [4:0] rd);
    int waited;
    bit fell;
    bit finished;
    faulted  = 1'b0;
    loaded   = 1'b0;
    data     = 32'h0;
    rd       = 5'h0;
    waited   = 0;
    fell     = 1'b0;
    finished = 1'b0;
    @(negedge clk);
    assert (ready) else fail_run("ready was low when an instruction was about to issue");
    @(posedge clk);
    issue     <= 1'b1;
    instr     <= word;
    rs1_value <= rs1;
    rs2_value <= rs2;
    @(posedge clk);
    issue <= 1'b0;
    while (!finished) begin
      @(negedge clk);
      waited++;
      if (fault) begin
        assert (!fell) else fail_run("fault pulsed while a bus access was running");
        faulted  = 1'b1;
        finished = 1'b1;
      end else if (!ready) begin
        fell = 1'b1;
      end else if (fell) begin
        finished = 1'b1;
        loaded   = load_done;
        data     = load_data;
        rd       = load_rd;
      end else begin
        assert (waited < 4) else fail_run("ready did not fall after a legal instruction");
      end
      if (!finished) begin
        assert (!load_done) else fail_run("load_done pulsed before ready returned high");
      end
    end
    @(negedge clk);
    assert (!load_done && !fault) else fail_run("load_done or fault lasted more than a cycle");
    assert (ready) else fail_run("ready fell again after the access had ended");
  endtask

  initial begin
    int limit;
    wait (table_ready);
    limit = (tab_instr.size() + NUM_RANDOM + WINDOW_WORDS + 8) * 64;
    repeat (limit) @(posedge clk);
    fail_run("timeout: the accesses did not all complete in the allowed time");
  end

  initial begin
    bit          faulted;
    bit          loaded;
    bit          have_load;
    bit          is_load;
    bit          store;
    bit          zext;
    logic [31:0] data;
    logic [4:0]  rd;
    logic [31:0] last_data;
    logic [4:0]  last_rd;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] imm_ext;
    logic [11:0] imm;
    logic [1:0]  size_code;

    issue     = 1'b0;
    instr     = 32'h0;
    rs1_value = 32'h0;
    rs2_value = 32'h0;
    rst       = 1'b0;
    have_load = 1'b0;
    last_data = 32'h0;
    last_rd   = 5'h0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    assert (ready && !load_done && !fault) else fail_run("outputs not idle after reset");

    for (int i = 0; i < tab_instr.size(); i++) begin
      run_access(tab_instr[i], tab_rs1[i], tab_rs2[i], faulted, loaded, data, rd);
      is_load = tab_instr[i][6:0] == 7'b0000011;
      check_value("fault", 32'(faulted), 32'(tab_fault[i]));
      if (is_load && !tab_fault[i]) begin
        check_value("load_done", 32'(loaded), 32'h1);
        check_value("load_data", data, tab_value[i]);
        check_value("load_rd", 32'(rd), 32'(tab_instr[i][11:7]));
        have_load = 1'b1;
        last_data = data;
        last_rd   = rd;
      end else begin
        check_value("load_done", 32'(loaded), 32'h0);
        // the last load result is held.
        if (have_load) begin
          check_value("load_data", load_data, last_data);
          check_value("load_rd", 32'(load_rd), 32'(last_rd));
        end
      end
    end

    for (int w = 0; w < WINDOW_WORDS; w++) begin
      addr  = WINDOW_BASE + 32'(4 * w);
      wdata = $random(seed);
      run_access(encode_store(F3_W, 12'h000), addr, wdata, faulted, loaded, data, rd);
      check_value("fault", 32'(faulted), 32'h0);
      shadow_store(addr, 2'b10, wdata);
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      r         = $random(seed);
      wdata     = $random(seed);
      store     = r[0];
      size_code = (r[2:1] == 2'b11) ? 2'b10 : r[2:1];
      addr      = WINDOW_BASE + {25'h0, r[9:5], 2'b00};
      if (size_code == 2'b00) begin
        addr[1:0] = r[4:3];
      end else if (size_code == 2'b01) begin
        addr[1] = r[4];
      end
      zext    = r[10] && (size_code != 2'b10);
      imm     = r[27:16];
      imm_ext = {{20{imm[11]}}, imm};
      if (store) begin
        run_access(encode_store({1'b0, size_code}, imm), addr - imm_ext, wdata,
                   faulted, loaded, data, rd);
        check_value("fault", 32'(faulted), 32'h0);
        check_value("load_done", 32'(loaded), 32'h0);
        shadow_store(addr, size_code, wdata);
      end else begin
        run_access(encode_load({zext, size_code}, r[15:11], imm), addr - imm_ext, 32'h0,
                   faulted, loaded, data, rd);
        check_value("fault", 32'(faulted), 32'h0);
        check_value("load_done", 32'(loaded), 32'h1);
        check_value("load_data", data, expected_load(addr, size_code, zext));
        check_value("load_rd", 32'(rd), 32'(r[15:11]));
      end
    end

    $display("Test OK");
    $finish;
  end

endmodule

/* load_store_unit.f */
logic/lsu_pkg.sv
logic/lsu_decode.sv
logic/data_manager.sv
logic/avalon_data_ram.sv
logic/load_store_unit.sv
testbench/load_store_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= load_store_unit_tb
FILELIST  ?= load_store_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q '^Test OK$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
